// ==== Bender.yml ====
package:
  name: core_slice

sources:
  - src/core_pkg.sv
  - src/instr_buffer.sv
  - src/issue_stage.sv
  - src/regfile.sv
  - src/exec_stage.sv
  - src/core_regs.sv
  - src/core_top.sv
  - target: test
    files:
      - tests/core_properties.sv
      - tests/core_tb.sv

// ==== files.f ====
src/core_pkg.sv
src/instr_buffer.sv
src/issue_stage.sv
src/regfile.sv
src/exec_stage.sv
src/core_regs.sv
src/core_top.sv
tests/core_properties.sv
tests/core_tb.sv

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int ib_depth = 8;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_xor  = 4'h4,
    op_slt  = 4'h5,
    op_addi = 4'h6,
    op_lui  = 4'h7
  } op_e;

  // register form
  typedef struct packed {
    logic [3:0]  opcode;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [12:0] unused;
  } instr_r_t;

  // immediate form
  typedef struct packed {
    logic [3:0]  opcode;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    logic [1:0]  unused;
    logic [15:0] imm16;
  } instr_i_t;

  // rs2 overlaps the top of imm16
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

  typedef struct packed {
    logic            valid;
    op_e             op;
    reg_addr_t       rd;
    logic            we;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } issue_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    reg_addr_t       rd;
    logic [xlen-1:0] data;
  } wb_t;

  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [11:0]     paddr;
    logic [xlen-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic            pready;
    logic [xlen-1:0] prdata;
    logic            pslverr;
  } apb_rsp_t;

  localparam logic [11:0] reg_push     = 12'h000;
  localparam logic [11:0] reg_status   = 12'h004;
  localparam logic [11:0] reg_retired  = 12'h008;
  localparam logic [11:0] reg_gpr_base = 12'h080;

endpackage

`default_nettype wire

// ==== src/core_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_regs import core_pkg::*; (
  input  logic            aclk,
  input  logic            rst_n,
  input  apb_req_t        apb_req,
  output apb_rsp_t        apb_rsp,
  output logic            push_valid,
  output instr_t          push_instr,
  input  logic            buf_full,
  input  logic [4:0]      buf_level,
  input  logic            core_busy,
  input  wb_t             wb [2],
  output reg_addr_t       dbg_addr,
  input  logic [xlen-1:0] dbg_data
);

  logic            access;
  logic            hit_push;
  logic            hit_status;
  logic            hit_retired;
  logic            hit_gpr;
  logic            mapped;
  logic            ro_write;
  logic            push_wr;
  logic [xlen-1:0] status;
  logic [xlen-1:0] retired;

  assign access = apb_req.psel && apb_req.penable;

  // address decode
  assign hit_push    = (apb_req.paddr == reg_push);
  assign hit_status  = (apb_req.paddr == reg_status);
  assign hit_retired = (apb_req.paddr == reg_retired);
  assign hit_gpr     = (apb_req.paddr[11:7] == reg_gpr_base[11:7]) &&
                       (apb_req.paddr[1:0] == 2'b00);
  assign mapped      = hit_push || hit_status || hit_retired || hit_gpr;
  assign ro_write    = apb_req.pwrite && (hit_status || hit_retired || hit_gpr);

  assign push_wr    = access && apb_req.pwrite && hit_push;
  assign push_valid = push_wr && !buf_full;
  assign push_instr = instr_t'(apb_req.pwdata);

  // register window goes straight to the debug port
  assign dbg_addr = apb_req.paddr[6:2];

  assign status = {23'b0, core_busy, 3'b0, buf_level};

  always_comb begin
    // wait states only while a push finds the buffer full
    apb_rsp.pready  = !(push_wr && buf_full);
    apb_rsp.pslverr = access && (!mapped || ro_write);
    apb_rsp.prdata  = '0;
    if (access && !apb_req.pwrite) begin
      if (hit_status) begin
        apb_rsp.prdata = status;
      end else if (hit_retired) begin
        apb_rsp.prdata = retired;
      end else if (hit_gpr) begin
        apb_rsp.prdata = dbg_data;
      end
    end
  end

  // up to two retirements per cycle
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      retired <= '0;
    end else begin
      retired <= retired + xlen'(wb[0].valid) + xlen'(wb[1].valid);
    end
  end

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
  input  logic     aclk,
  input  logic     rst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic            push_valid;
  instr_t          push_instr;
  instr_t          head0;
  instr_t          head1;
  logic [4:0]      buf_level;
  logic            buf_full;
  logic [1:0]      pop_count;
  reg_addr_t       rs_addr [4];
  logic [xlen-1:0] rs_data [4];
  issue_t          slot [2];
  wb_t             wb [2];
  reg_addr_t       dbg_addr;
  logic [xlen-1:0] dbg_data;
  logic            core_busy;

  core_regs core_regs (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .push_valid (push_valid),
    .push_instr (push_instr),
    .buf_full   (buf_full),
    .buf_level  (buf_level),
    .core_busy  (core_busy),
    .wb         (wb),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data)
  );

  instr_buffer #(
    .depth (ib_depth)
  ) instr_buffer (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_instr (push_instr),
    .head0      (head0),
    .head1      (head1),
    .level      (buf_level),
    .full       (buf_full),
    .pop_count  (pop_count)
  );

  issue_stage issue_stage (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .head0     (head0),
    .head1     (head1),
    .level     (buf_level),
    .pop_count (pop_count),
    .rs_addr   (rs_addr),
    .rs_data   (rs_data),
    .slot      (slot),
    .wb        (wb),
    .busy_in   (|buf_level),
    .busy      (core_busy)
  );

  regfile regfile (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .rs_addr  (rs_addr),
    .rs_data  (rs_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data),
    .wb       (wb)
  );

  exec_stage exec_stage (
    .aclk  (aclk),
    .rst_n (rst_n),
    .slot  (slot),
    .wb    (wb)
  );

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_stage import core_pkg::*; (
  input  logic   aclk,
  input  logic   rst_n,
  input  issue_t slot [2],
  output wb_t    wb [2]
);

  function automatic logic [xlen-1:0] alu(input issue_t s);
    logic [xlen-1:0] res;
    case (s.op)
      op_add, op_addi: begin
        res = s.a + s.b;
      end
      op_sub: begin
        res = s.a - s.b;
      end
      op_and: begin
        res = s.a & s.b;
      end
      op_or: begin
        res = s.a | s.b;
      end
      op_xor: begin
        res = s.a ^ s.b;
      end
      op_slt: begin
        res = {{(xlen - 1){1'b0}}, $signed(s.a) < $signed(s.b)};
      end
      // operand b already holds the shifted immediate
      op_lui: begin
        res = s.b;
      end
      default: begin
        res = '0;
      end
    endcase
    return res;
  endfunction

  for (genvar i = 0; i < 2; i++) begin : g_lane
    logic [xlen-1:0] result;

    assign result = alu(slot[i]);

    always_ff @(posedge aclk) begin
      wb[i] <= '{
        valid: slot[i].valid,
        we:    slot[i].we,
        rd:    slot[i].rd,
        data:  result
      };
      if (!rst_n) begin
        wb[i].valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/instr_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_buffer import core_pkg::*; #(
  parameter int depth = ib_depth
) (
  input  logic       aclk,
  input  logic       rst_n,
  input  logic       push_valid,
  input  instr_t     push_instr,
  output instr_t     head0,
  output instr_t     head1,
  output logic [4:0] level,
  output logic       full,
  input  logic [1:0] pop_count
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [aw:0] depth_w = (aw + 1)'(depth);

  instr_t        mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic          push;

  // wrapping pointer advance for any depth
  function automatic logic [aw-1:0] ptr_add(input logic [aw-1:0] ptr, input logic [1:0] n);
    logic [aw:0] sum;
    sum = (aw + 1)'(ptr) + (aw + 1)'(n);
    if (sum >= depth_w) begin
      sum = sum - depth_w;
    end
    return sum[aw-1:0];
  endfunction

  assign full = (level == 5'(depth));
  assign push = push_valid && !full;

  assign head0 = mem[rd_ptr];
  assign head1 = mem[ptr_add(rd_ptr, 2'd1)];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_instr;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_add(wr_ptr, 2'd1);
      end
      rd_ptr <= ptr_add(rd_ptr, pop_count);
      // push and pop may happen together
      level  <= level + 5'(push) - 5'(pop_count);
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_stage import core_pkg::*; (
  input  logic            aclk,
  input  logic            rst_n,
  input  instr_t          head0,
  input  instr_t          head1,
  input  logic [4:0]      level,
  output logic [1:0]      pop_count,
  output reg_addr_t       rs_addr [4],
  input  logic [xlen-1:0] rs_data [4],
  output issue_t          slot [2],
  input  wb_t             wb [2],
  input  logic            busy_in,
  output logic            busy
);

  typedef struct packed {
    logic use_rs1;
    logic use_rs2;
    logic we;
  } dec_t;

  dec_t dec0;
  dec_t dec1;
  logic haz0;
  logic haz1;
  logic raw01;
  logic issue0;
  logic issue1;

  function automatic dec_t decode(input instr_t ins);
    dec_t d;
    d = '0;
    case (ins.r.opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        d.use_rs1 = 1'b1;
        d.use_rs2 = 1'b1;
        d.we      = 1'b1;
      end
      op_addi: begin
        d.use_rs1 = 1'b1;
        d.we      = 1'b1;
      end
      op_lui: d.we = 1'b1;
      // undefined opcodes read and write nothing
      default: d = '0;
    endcase
    if (ins.r.rd == '0) begin
      d.we = 1'b0;
    end
    return d;
  endfunction

  function automatic logic reads_reg(input instr_t ins, input dec_t d, input reg_addr_t r);
    return (d.use_rs1 && ins.r.rs1 == r) || (d.use_rs2 && ins.r.rs2 == r);
  endfunction

  // result still in the execute register and not yet bypassed
  function automatic logic blocked(input instr_t ins, input dec_t d);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (slot[i].valid && slot[i].we && reads_reg(ins, d, slot[i].rd)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic issue_t build(input logic v, input instr_t ins, input dec_t d,
                                   input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    issue_t s;
    s.valid = v;
    s.op    = op_e'(ins.r.opcode);
    s.rd    = ins.r.rd;
    s.we    = d.we;
    s.a     = a;
    case (ins.r.opcode)
      op_addi: s.b = {{(xlen - 16){ins.i.imm16[15]}}, ins.i.imm16};
      op_lui:  s.b = {ins.i.imm16, 16'h0000};
      default: s.b = b;
    endcase
    return s;
  endfunction

  always_comb begin
    dec0   = decode(head0);
    dec1   = decode(head1);
    haz0   = blocked(head0, dec0);
    haz1   = blocked(head1, dec1);
    raw01  = dec0.we && reads_reg(head1, dec1, head0.r.rd);
    issue0 = (level != '0) && !haz0;
    issue1 = issue0 && (level >= 5'd2) && !haz1 && !raw01;
  end

  assign pop_count = issue1 ? 2'd2 : (issue0 ? 2'd1 : 2'd0);

  assign rs_addr[0] = head0.r.rs1;
  assign rs_addr[1] = head0.r.rs2;
  assign rs_addr[2] = head1.r.rs1;
  assign rs_addr[3] = head1.r.rs2;

  always_ff @(posedge aclk) begin
    slot[0] <= build(issue0, head0, dec0, rs_data[0], rs_data[1]);
    slot[1] <= build(issue1, head1, dec1, rs_data[2], rs_data[3]);
    if (!rst_n) begin
      slot[0].valid <= 1'b0;
      slot[1].valid <= 1'b0;
    end
  end

  assign busy = busy_in || slot[0].valid || slot[1].valid || wb[0].valid || wb[1].valid;

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile import core_pkg::*; (
  input  logic            aclk,
  input  logic            rst_n,
  input  reg_addr_t       rs_addr [4],
  output logic [xlen-1:0] rs_data [4],
  input  reg_addr_t       dbg_addr,
  output logic [xlen-1:0] dbg_data,
  input  wb_t             wb [2]
);

  logic [xlen-1:0] regs [32];

  // write-through bypass with the younger lane 1 first
  function automatic logic [xlen-1:0] read_port(input reg_addr_t addr);
    logic [xlen-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wb[1].valid && wb[1].we && wb[1].rd == addr) begin
      data = wb[1].data;
    end else if (wb[0].valid && wb[0].we && wb[0].rd == addr) begin
      data = wb[0].data;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rs_data[i] = read_port(rs_addr[i]);
    end
    dbg_data = read_port(dbg_addr);
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // lane 1 written last so it wins on equal rd
      for (int l = 0; l < 2; l++) begin
        if (wb[l].valid && wb[l].we && wb[l].rd != '0) begin
          regs[wb[l].rd] <= wb[l].data;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/core_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_properties import core_pkg::*; (
  input logic       aclk,
  input logic       rst_n,
  input logic [4:0] level,
  input logic [1:0] pop_count,
  input issue_t     slot [2],
  input wb_t        wb [2],
  input logic       busy
);

  int unsigned fail_count = 0;

  // never pop more than the buffer holds
  pop_within_level: assert property (@(posedge aclk) disable iff (!rst_n)
    5'(pop_count) <= level)
  else begin
    fail_count++;
    $error("pop count %0d above buffer level %0d", pop_count, level);
  end

  // execute never holds back a result
  lane0_reaches_wb: assert property (@(posedge aclk) disable iff (!rst_n)
    slot[0].valid |=> wb[0].valid && wb[0].rd == $past(slot[0].rd))
  else begin
    fail_count++;
    $error("lane 0 result missing in write-back");
  end

  lane1_reaches_wb: assert property (@(posedge aclk) disable iff (!rst_n)
    slot[1].valid |=> wb[1].valid && wb[1].rd == $past(slot[1].rd))
  else begin
    fail_count++;
    $error("lane 1 result missing in write-back");
  end

  // idle only with an empty buffer
  idle_means_empty: assert property (@(posedge aclk) disable iff (!rst_n)
    !busy |-> level == 5'd0)
  else begin
    fail_count++;
    $error("busy low with buffer level %0d", level);
  end

endmodule

bind issue_stage core_properties props (
  .aclk      (aclk),
  .rst_n     (rst_n),
  .level     (level),
  .pop_count (pop_count),
  .slot      (slot),
  .wb        (wb),
  .busy      (busy)
);

`default_nettype wire

// ==== tests/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb import core_pkg::*; ;

  typedef struct packed {
    logic        write;
    logic [11:0] addr;
    logic        err;
  } access_t;

  logic            aclk = 1'b0;
  logic            rst_n;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  apb_rsp_t        rsp_q;
  apb_rsp_t        rsp_ok;
  apb_rsp_t        rsp_err;
  integer          seed;
  int              watchdog_cycles = 0;
  instr_t          prog_table [$];
  int              prog_len [$];
  access_t         access_table [8];
  logic [xlen-1:0] model [32];
  logic [xlen-1:0] model_retired;

  core_top UUT (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #50 aclk = ~aclk;

  // response as seen by the completing posedge
  always @(posedge aclk) begin
    rsp_q <= apb_rsp;
  end

  function automatic logic [15:0] rnd16();
    logic [31:0] v;
    v = $random(seed);
    return v[15:0];
  endfunction

  function automatic instr_t enc_r(input logic [3:0] op, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2);
    return instr_t'({op, rd, rs1, rs2, 13'h0000});
  endfunction

  function automatic instr_t enc_i(input logic [3:0] op, input reg_addr_t rd,
                                   input reg_addr_t rs1, input logic [15:0] imm);
    return instr_t'({op, rd, rs1, 2'b00, imm});
  endfunction

  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
      $display("MISMATCH %s: pready %h pslverr %h expected pready %h pslverr %h",
               name, got.pready, got.pslverr, exp.pready, exp.pslverr);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // setup cycle then access cycles until pready
  task automatic bus_xfer(input logic write, input logic [11:0] addr,
                          input logic [xlen-1:0] data, output apb_rsp_t rsp, output int waits);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge aclk);
    apb_req.penable = 1'b1;
    @(negedge aclk);
    waits = 0;
    while (!rsp_q.pready) begin
      @(negedge aclk);
      waits++;
    end
    rsp = rsp_q;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // sequential reference running one instruction at a time
  task automatic model_exec(input instr_t ins);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] res;
    logic            wr;
    a   = model[ins.r.rs1];
    b   = model[ins.r.rs2];
    res = '0;
    wr  = 1'b1;
    case (ins.r.opcode)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_addi: res = a + {{16{ins.i.imm16[15]}}, ins.i.imm16};
      op_lui:  res = {ins.i.imm16, 16'h0000};
      default: wr = 1'b0;
    endcase
    if (wr && ins.r.rd != 5'd0) begin
      model[ins.r.rd] = res;
    end
    model_retired++;
  endtask

  task automatic check_all_regs();
    apb_rsp_t rsp;
    int       w;
    for (int i = 0; i < 32; i++) begin
      bus_xfer(1'b0, reg_gpr_base + 12'(i * 4), '0, rsp, w);
      check_rsp($sformatf("read x%0d", i), rsp, rsp_ok);
      check_word($sformatf("x%0d", i), rsp.prdata, model[i]);
    end
    bus_xfer(1'b0, reg_retired, '0, rsp, w);
    check_count("retired", rsp.prdata, model_retired);
  endtask

  task automatic wait_idle();
    apb_rsp_t rsp;
    int       w;
    rsp.prdata = 32'h0000_0100;
    while (rsp.prdata[8]) begin
      bus_xfer(1'b0, reg_status, '0, rsp, w);
      check_rsp("status read", rsp, rsp_ok);
    end
    check_word("status", rsp.prdata, '0);
  endtask

  task automatic run_program(input int p, input int start, input int len);
    apb_rsp_t rsp;
    int       w;
    int       waits;
    waits = 0;
    for (int i = start; i < start + len; i++) begin
      bus_xfer(1'b1, reg_push, prog_table[i], rsp, w);
      check_rsp($sformatf("push %0d", i), rsp, rsp_ok);
      model_exec(prog_table[i]);
      waits += w;
    end
    $display("program %0d: %0d instructions, %0d push wait states", p, len, waits);
    wait_idle();
    check_all_regs();
  endtask

  task automatic build_programs();
    int n;
    // random operands then all eight operations
    n = prog_table.size();
    for (int r = 1; r <= 8; r++) begin
      prog_table.push_back(enc_i(op_lui, 5'(r), 5'd0, rnd16()));
      prog_table.push_back(enc_i(op_addi, 5'(r), 5'(r), rnd16()));
    end
    prog_table.push_back(enc_r(op_add, 5'd9, 5'd1, 5'd2));
    prog_table.push_back(enc_r(op_sub, 5'd10, 5'd3, 5'd4));
    prog_table.push_back(enc_r(op_and, 5'd11, 5'd5, 5'd6));
    prog_table.push_back(enc_r(op_or, 5'd12, 5'd7, 5'd8));
    prog_table.push_back(enc_r(op_xor, 5'd13, 5'd1, 5'd8));
    prog_table.push_back(enc_r(op_slt, 5'd14, 5'd5, 5'd6));
    prog_table.push_back(enc_r(op_slt, 5'd15, 5'd6, 5'd5));
    prog_table.push_back(enc_i(op_addi, 5'd16, 5'd7, rnd16()));
    prog_table.push_back(enc_i(op_lui, 5'd17, 5'd0, rnd16()));
    prog_len.push_back(prog_table.size() - n);
    // dependent chain, independent pair, same rd pair, pair with RAW
    n = prog_table.size();
    prog_table.push_back(enc_r(op_add, 5'd18, 5'd1, 5'd2));
    prog_table.push_back(enc_r(op_add, 5'd18, 5'd18, 5'd3));
    prog_table.push_back(enc_r(op_sub, 5'd18, 5'd18, 5'd4));
    prog_table.push_back(enc_r(op_xor, 5'd19, 5'd18, 5'd1));
    prog_table.push_back(enc_r(op_slt, 5'd19, 5'd19, 5'd18));
    prog_table.push_back(enc_r(op_add, 5'd20, 5'd1, 5'd2));
    prog_table.push_back(enc_r(op_sub, 5'd21, 5'd3, 5'd4));
    prog_table.push_back(enc_r(op_add, 5'd22, 5'd5, 5'd6));
    prog_table.push_back(enc_r(op_xor, 5'd22, 5'd7, 5'd8));
    prog_table.push_back(enc_r(op_or, 5'd23, 5'd5, 5'd6));
    prog_table.push_back(enc_r(op_and, 5'd24, 5'd23, 5'd7));
    prog_table.push_back(enc_i(op_addi, 5'd25, 5'd0, rnd16()));
    prog_table.push_back(enc_i(op_addi, 5'd26, 5'd25, rnd16()));
    prog_len.push_back(prog_table.size() - n);
    // more than ib_depth pushes back to back
    n = prog_table.size();
    for (int k = 0; k < 10; k++) begin
      prog_table.push_back(enc_i(op_addi, 5'd27, 5'd27, 16'd1));
      prog_table.push_back(enc_i(op_addi, 5'd28, 5'd28, 16'd3));
    end
    prog_table.push_back(enc_r(op_add, 5'd29, 5'd27, 5'd28));
    prog_len.push_back(prog_table.size() - n);
    // nothing here may change a register
    n = prog_table.size();
    prog_table.push_back(enc_r(op_add, 5'd0, 5'd1, 5'd2));
    prog_table.push_back(enc_i(op_addi, 5'd0, 5'd3, 16'h1234));
    prog_table.push_back(enc_i(op_lui, 5'd0, 5'd0, rnd16()));
    prog_table.push_back(enc_r(op_sub, 5'd0, 5'd0, 5'd4));
    for (int k = 0; k < 8; k++) begin
      prog_table.push_back(enc_r(4'(8 + k), 5'(k + 1), 5'(k + 2), 5'(k + 3)));
    end
    prog_len.push_back(prog_table.size() - n);
    // unmapped and read-only accesses
    access_table[0] = {1'b0, 12'h00c, 1'b1};
    access_table[1] = {1'b1, 12'h010, 1'b1};
    access_table[2] = {1'b1, reg_status, 1'b1};
    access_table[3] = {1'b1, reg_retired, 1'b1};
    access_table[4] = {1'b1, 12'h084, 1'b1};
    access_table[5] = {1'b0, 12'h100, 1'b1};
    access_table[6] = {1'b0, 12'h082, 1'b1};
    access_table[7] = {1'b0, reg_retired, 1'b0};
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge aclk);
    $display("watchdog expired after %0d cycles with tests still running", watchdog_cycles);
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  // a failed assertion ends the run at once
  always @(negedge aclk) begin
    if (UUT.issue_stage.props.fail_count != 0) begin
      $display("Test failures found");
      $fatal(1, "assertion failed in the issue stage");
    end
  end

  initial begin
    apb_rsp_t rsp;
    int       w;
    int       start;
    seed    = 32'h4a7f_f8f1;
    rst_n   = 1'b0;
    apb_req = '0;
    rsp_ok  = '0;
    rsp_ok.pready = 1'b1;
    rsp_err = rsp_ok;
    rsp_err.pslverr = 1'b1;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    model_retired = '0;
    build_programs();
    watchdog_cycles = 2000 + 20 * prog_table.size() + 300 * prog_len.size();
    repeat (2) @(negedge aclk);
    rst_n = 1'b1;
    @(negedge aclk);
    check_rsp("idle response", rsp_q, rsp_ok);
    bus_xfer(1'b0, reg_status, '0, rsp, w);
    check_rsp("status read", rsp, rsp_ok);
    check_word("status", rsp.prdata, '0);
    check_all_regs();
    start = 0;
    for (int p = 0; p < prog_len.size(); p++) begin
      run_program(p, start, prog_len[p]);
      start += prog_len[p];
    end
    for (int k = 0; k < 8; k++) begin
      bus_xfer(access_table[k].write, access_table[k].addr, {rnd16(), rnd16()}, rsp, w);
      check_rsp($sformatf("access %0d", k), rsp, access_table[k].err ? rsp_err : rsp_ok);
    end
    wait_idle();
    check_all_regs();
    if (UUT.issue_stage.props.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "%0d assertion failures", UUT.issue_stage.props.fail_count);
    end
  end

endmodule

`default_nettype wire
